//--- files.f
design/xip_pkg.sv
design/word_stream_if.sv
design/host_port.sv
design/write_fifo.sv
design/flash_sequencer.sv
design/command_builder.sv
design/xip_controller.sv
bench/xip_assertions.sv
bench/xip_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= xip_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_TEXT ?= TEST PASS

.PHONY: sim clean

# Build and run; the status comes from the search for the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- bench/xip_tb.sv
`timescale 1ns/1ps

module xip_tb;

    localparam int TIMEOUT = 200;
    localparam int OPS     = 30;

    logic        clk;
    logic        reset;
    logic [31:0] mem_addr;
    logic        mem_rd;
    logic        mem_wr;
    logic [31:0] mem_wrdata;
    logic [6:0]  mem_burstcount;
    logic        mem_waitrequest;
    logic [31:0] mem_rddata;
    logic        mem_rddatavalid;
    logic        cmd_valid;
    logic        cmd_ready;
    logic        cmd_sop;
    logic        cmd_eop;
    logic [31:0] cmd_data;
    logic        rsp_valid;
    logic [31:0] rsp_data;
    logic        rsp_eop;
    logic [3:0]  chip_select;
    logic [31:0] addr_bytes_xip;

    // Flash model contents and captured read beats
    logic [31:0] lcg_state = 32'hc70f;
    logic [31:0] flash_mem [256];
    logic [31:0] rd_seen [$];

    xip_controller #(.ADDR_W(32), .FIFO_DEPTH(64)) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Read data is collected mid-cycle
    always @(negedge clk) begin
        if (mem_rddatavalid) begin
            rd_seen.push_back(mem_rddata);
        end
    end

    // ****************************************
    // Helpers
    // ****************************************
    // Halves swapped so the low bits come from the better LCG bits
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {lcg_state[15:0], lcg_state[31:16]};
    endfunction

    // Flags are has_dummy, has_data_out, has_data_in, four_byte_addr, has_addr
    function automatic logic [31:0] expected_header(input logic [7:0] opcode,
        input logic [8:0] bytes, input logic [4:0] dummy, input logic [4:0] flags);
        return {1'b0, chip_select, bytes, dummy, flags, opcode};
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else report_failure($sformatf("Fail %s exp %h got %h",
                                                           name, exp, got));
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // Waits for waitrequest low, then steps past the accepting edge
    task automatic wait_ready(input string what);
        int waited = 0;
        @(negedge clk);
        while (mem_waitrequest) begin
            waited++;
            assert (waited < TIMEOUT) else report_failure(what);
            @(negedge clk);
        end
        tick();
    endtask

    // Flash side takes one command word after a random ready gap
    task automatic expect_command(input logic [31:0] exp, input logic exp_sop,
                                  input logic exp_eop);
        int gap;
        int waited;
        gap    = int'(next_rand() % 4);
        waited = 0;
        repeat (gap) tick();
        cmd_ready = 1'b1;
        @(negedge clk);
        while (!cmd_valid) begin
            waited++;
            assert (waited < TIMEOUT) else report_failure("command word never arrived");
            @(negedge clk);
        end
        check_word("cmd_data", cmd_data, exp);
        check_word("cmd_sop", 32'(cmd_sop), 32'(exp_sop));
        check_word("cmd_eop", 32'(cmd_eop), 32'(exp_eop));
        tick();
        cmd_ready = 1'b0;
    endtask

    task automatic send_response(input logic [31:0] data, input logic eop);
        rsp_valid = 1'b1;
        rsp_data  = data;
        rsp_eop   = eop;
        tick();
        rsp_valid = 1'b0;
        rsp_eop   = 1'b0;
    endtask

    // ****************************************
    // Operations
    // ****************************************
    task automatic run_write(input int addr, input int len);
        logic [31:0] words [$];
        int          status_busy;
        int          flag_busy;
        status_busy = int'(next_rand() % 4);
        flag_busy   = int'(next_rand() % 4);
        rd_seen.delete();
        // Whole burst lands in the FIFO before any command goes out
        for (int i = 0; i < len; i++) begin
            words.push_back(next_rand());
            mem_wr         = 1'b1;
            mem_addr       = 32'(addr);
            mem_burstcount = 7'(len);
            mem_wrdata     = words[i];
            wait_ready("write beat never accepted");
            if (i == 0) begin
                check_word("addr_bytes_xip", addr_bytes_xip, 32'(addr) << 2);
            end
        end
        mem_wr = 1'b0;
        // Busy replies keep the controller polling status
        repeat (status_busy) begin
            expect_command(expected_header(xip_pkg::OP_READ_STATUS, 9'd1, 5'd0, 5'b00100),
                           1'b1, 1'b1);
            send_response(next_rand() | 32'h1, 1'b1);
        end
        expect_command(expected_header(xip_pkg::OP_READ_STATUS, 9'd1, 5'd0, 5'b00100),
                       1'b1, 1'b1);
        send_response(next_rand() & ~32'h1, 1'b1);
        expect_command(expected_header(xip_pkg::OP_WRITE_ENABLE, 9'd0, 5'd0, 5'b00000),
                       1'b1, 1'b1);
        send_response(32'h0, 1'b1);
        expect_command(expected_header(xip_pkg::OP_WRITE, 9'(len * 4), 5'd0, 5'b01001),
                       1'b1, 1'b0);
        for (int i = 0; i < len; i++) begin
            expect_command(words[i], 1'b0, i == len - 1);
            flash_mem[8'(addr + i)] = words[i];
        end
        send_response(32'h0, 1'b1);
        // Program completes once the flag ready bit is seen
        repeat (flag_busy) begin
            expect_command(expected_header(xip_pkg::OP_READ_FLAG_STATUS, 9'd1, 5'd0,
                                           5'b00100), 1'b1, 1'b1);
            send_response(next_rand() & ~32'h80, 1'b1);
        end
        expect_command(expected_header(xip_pkg::OP_READ_FLAG_STATUS, 9'd1, 5'd0, 5'b00100),
                       1'b1, 1'b1);
        send_response(next_rand() | 32'h80, 1'b1);
        wait_ready("write never completed");
        check_word("mem_rddatavalid count", 32'(rd_seen.size()), 32'h0);
    endtask

    task automatic run_read(input int addr, input int len);
        logic [31:0] nvcr;
        logic [3:0]  field;
        logic [4:0]  dummy;
        nvcr = next_rand();
        // Bias toward the erased and unset dummy codes
        if (next_rand() % 3 == 0) nvcr[15:12] = nvcr[0] ? 4'hF : 4'h0;
        field = nvcr[15:12];
        dummy = (field == 4'h0 || field == 4'hF) ? 5'd8 : {1'b0, field};
        rd_seen.delete();
        mem_rd         = 1'b1;
        mem_addr       = 32'(addr);
        mem_burstcount = 7'(len);
        wait_ready("read request never accepted");
        mem_rd = 1'b0;
        check_word("addr_bytes_xip", addr_bytes_xip, 32'(addr) << 2);
        expect_command(expected_header(xip_pkg::OP_READ_NVCR, 9'd2, 5'd0, 5'b00100),
                       1'b1, 1'b1);
        send_response(nvcr, 1'b1);
        expect_command(expected_header(xip_pkg::OP_FAST_READ, 9'(len * 4), dummy, 5'b10101),
                       1'b1, 1'b1);
        for (int i = 0; i < len; i++) begin
            send_response(flash_mem[8'(addr + i)], i == len - 1);
        end
        wait_ready("read never completed");
        check_word("mem_rddatavalid count", 32'(rd_seen.size()), 32'(len));
        foreach (rd_seen[i]) begin
            check_word("mem_rddata", rd_seen[i], flash_mem[8'(addr + i)]);
        end
    endtask

    // ****************************************
    // Main sequence
    // ****************************************
    initial begin
        int addr;
        int len;
        reset          = 1'b1;
        mem_addr       = '0;
        mem_rd         = 1'b0;
        mem_wr         = 1'b0;
        mem_wrdata     = '0;
        mem_burstcount = '0;
        cmd_ready      = 1'b0;
        rsp_valid      = 1'b0;
        rsp_data       = '0;
        rsp_eop        = 1'b0;
        chip_select    = 4'h3;
        for (int i = 0; i < 256; i++) begin
            flash_mem[i] = (32'(i) * 32'h9e37_79b9) ^ 32'h0f0f_1234;
        end
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        // Waitrequest held for one cycle, then quiet idle outputs
        @(negedge clk);
        check_word("mem_waitrequest", 32'(mem_waitrequest), 32'h1);
        repeat (3) begin
            tick();
            check_word("mem_waitrequest", 32'(mem_waitrequest), 32'h0);
            check_word("cmd_valid", 32'(cmd_valid), 32'h0);
            check_word("mem_rddatavalid", 32'(mem_rddatavalid), 32'h0);
        end
        // Directed write then read-back of the same words
        run_write(16, 8);
        run_read(16, 8);
        for (int n = 0; n < OPS; n++) begin
            addr        = int'(next_rand() % 248);
            len         = int'(next_rand() % 8) + 1;
            chip_select = 4'(next_rand());
            if (next_rand() % 2 == 0) begin
                run_write(addr, len);
            end else begin
                run_read(addr, len);
            end
        end
        if (UUT.prop_checks.violations == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- bench/xip_assertions.sv
`timescale 1ns/1ps

module xip_assertions (
    input logic        clk,
    input logic        reset,
    input logic        mem_waitrequest,
    input logic        mem_rddatavalid,
    input logic        cmd_valid,
    input logic        cmd_ready,
    input logic        cmd_sop,
    input logic [31:0] cmd_data
);

    int violations = 0;

    // ****************************************
    // Command stream protocol
    // ****************************************
    sop_needs_valid: assert property (@(posedge clk) disable iff (reset)
        cmd_sop |-> cmd_valid)
        else begin
            $error("cmd_sop seen without cmd_valid");
            violations++;
        end

    // Stalled word stays offered and unchanged
    valid_holds: assert property (@(posedge clk) disable iff (reset)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_data))
        else begin
            $error("cmd_valid or cmd_data changed under back-pressure");
            violations++;
        end

    // Read data only arrives while the host is held off
    rddata_while_busy: assert property (@(posedge clk) disable iff (reset)
        $rose(mem_rddatavalid) |-> mem_waitrequest)
        else begin
            $error("mem_rddatavalid rose while mem_waitrequest was low");
            violations++;
        end

endmodule

bind xip_controller xip_assertions prop_checks (
    .clk(clk),
    .reset(reset),
    .mem_waitrequest(mem_waitrequest),
    .mem_rddatavalid(mem_rddatavalid),
    .cmd_valid(cmd_valid),
    .cmd_ready(cmd_ready),
    .cmd_sop(cmd_sop),
    .cmd_data(cmd_data)
);

//--- design/xip_controller.sv
`timescale 1ns/1ps

module xip_controller #(
    parameter int ADDR_W     = 32,
    parameter int FIFO_DEPTH = 64
) (
    input  logic                        clk,
    input  logic                        reset,
    // Host bus
    input  logic [ADDR_W-1:0]           mem_addr,
    input  logic                        mem_rd,
    input  logic                        mem_wr,
    input  logic [xip_pkg::WORD_W-1:0]  mem_wrdata,
    input  logic [xip_pkg::BURST_W-1:0] mem_burstcount,
    output logic                        mem_waitrequest,
    output logic [xip_pkg::WORD_W-1:0]  mem_rddata,
    output logic                        mem_rddatavalid,
    // Command stream toward the flash
    output logic                        cmd_valid,
    input  logic                        cmd_ready,
    output logic                        cmd_sop,
    output logic                        cmd_eop,
    output logic [xip_pkg::WORD_W-1:0]  cmd_data,
    // Response stream, always accepted
    input  logic                        rsp_valid,
    input  logic [xip_pkg::WORD_W-1:0]  rsp_data,
    input  logic                        rsp_eop,
    input  logic [3:0]                  chip_select,
    output logic [ADDR_W-1:0]           addr_bytes_xip
);

    logic                        read_start;
    logic                        write_start;
    logic                        seq_idle;
    logic                        fifo_push;
    logic [xip_pkg::WORD_W-1:0]  fifo_word;
    logic                        fifo_eop;
    logic [xip_pkg::BURST_W-1:0] burst_len;
    logic [4:0]                  dummy_count;
    xip_pkg::seq_state_t         seq_state;

    word_stream_if wr_stream ();

    host_port #(.ADDR_W(ADDR_W)) u_host_port (
        .clk, .reset, .mem_addr, .mem_rd, .mem_wr, .mem_wrdata, .mem_burstcount,
        .idle(seq_idle), .mem_waitrequest, .read_start, .write_start,
        .fifo_push, .fifo_word, .fifo_eop, .burst_len, .addr_bytes_xip
    );

    write_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_write_fifo (
        .clk, .reset, .push(fifo_push), .word(fifo_word), .eop(fifo_eop),
        .out(wr_stream.source)
    );

    flash_sequencer u_sequencer (
        .clk, .reset, .read_start, .write_start, .cmd_ready,
        .rsp_valid, .rsp_data, .rsp_eop, .fifo(wr_stream.sink),
        .idle(seq_idle), .state(seq_state), .dummy_count,
        .mem_rddata, .mem_rddatavalid
    );

    command_builder u_cmd_builder (
        .state(seq_state), .dummy_count, .burst_len, .chip_select,
        .fifo(wr_stream.sink), .cmd_valid, .cmd_sop, .cmd_eop, .cmd_data
    );

endmodule

//--- design/command_builder.sv
`timescale 1ns/1ps

module command_builder (
    input  xip_pkg::seq_state_t         state,
    input  logic [4:0]                  dummy_count,
    input  logic [xip_pkg::BURST_W-1:0] burst_len,
    input  logic [3:0]                  chip_select,
    word_stream_if.sink                 fifo,
    output logic                        cmd_valid,
    output logic                        cmd_sop,
    output logic                        cmd_eop,
    output logic [xip_pkg::WORD_W-1:0]  cmd_data
);

    xip_pkg::cmd_header_t hdr;
    logic [8:0]           burst_bytes;

    // Full words only, so bytes are words times four
    assign burst_bytes = {burst_len, 2'b00};

    // ****************************************
    // Header per command state
    // ****************************************
    always_comb begin
        hdr             = '0;
        hdr.chip_select = chip_select;
        case (state)
            xip_pkg::ST_STATUS_CMD: begin
                hdr.opcode      = xip_pkg::OP_READ_STATUS;
                hdr.data_bytes  = 9'd1;
                hdr.has_data_in = 1'b1;
            end
            xip_pkg::ST_WREN_CMD: hdr.opcode = xip_pkg::OP_WRITE_ENABLE;
            xip_pkg::ST_WR_CMD: begin
                hdr.opcode       = xip_pkg::OP_WRITE;
                hdr.data_bytes   = burst_bytes;
                hdr.has_addr     = 1'b1;
                hdr.has_data_out = 1'b1;
            end
            xip_pkg::ST_POLL_CMD: begin
                hdr.opcode      = xip_pkg::OP_READ_FLAG_STATUS;
                hdr.data_bytes  = 9'd1;
                hdr.has_data_in = 1'b1;
            end
            // NVCR is two bytes wide
            xip_pkg::ST_CFG_CMD: begin
                hdr.opcode      = xip_pkg::OP_READ_NVCR;
                hdr.data_bytes  = 9'd2;
                hdr.has_data_in = 1'b1;
            end
            xip_pkg::ST_RD_CMD: begin
                hdr.opcode      = xip_pkg::OP_FAST_READ;
                hdr.data_bytes  = burst_bytes;
                hdr.dummy       = dummy_count;
                hdr.has_addr    = 1'b1;
                hdr.has_data_in = 1'b1;
                hdr.has_dummy   = 1'b1;
            end
            default: hdr.opcode = 8'h00;
        endcase
    end

    // Command stream mux
    always_comb begin
        cmd_valid = 1'b0;
        cmd_sop   = 1'b0;
        cmd_eop   = 1'b0;
        cmd_data  = hdr;
        case (state)
            xip_pkg::ST_STATUS_CMD, xip_pkg::ST_WREN_CMD, xip_pkg::ST_POLL_CMD,
            xip_pkg::ST_CFG_CMD, xip_pkg::ST_RD_CMD: begin
                // Single word packets
                cmd_valid = 1'b1;
                cmd_sop   = 1'b1;
                cmd_eop   = 1'b1;
            end
            xip_pkg::ST_WR_CMD: begin
                // Header opens the write packet, data follows
                cmd_valid = 1'b1;
                cmd_sop   = 1'b1;
            end
            xip_pkg::ST_WR_DATA: begin
                cmd_valid = fifo.valid;
                cmd_eop   = fifo.eop;
                cmd_data  = fifo.data;
            end
            default: cmd_valid = 1'b0;
        endcase
    end

endmodule

//--- design/flash_sequencer.sv
`timescale 1ns/1ps

module flash_sequencer (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       read_start,
    input  logic                       write_start,
    input  logic                       cmd_ready,
    input  logic                       rsp_valid,
    input  logic [xip_pkg::WORD_W-1:0] rsp_data,
    input  logic                       rsp_eop,
    word_stream_if.sink                fifo,
    output logic                       idle,
    output xip_pkg::seq_state_t        state,
    output logic [4:0]                 dummy_count,
    output logic [xip_pkg::WORD_W-1:0] mem_rddata,
    output logic                       mem_rddatavalid
);

    xip_pkg::seq_state_t next_state;
    logic                rsp_done;
    logic                busy;
    logic [3:0]          cfg_dummy;

    assign rsp_done  = rsp_valid && rsp_eop;
    assign cfg_dummy = rsp_data[xip_pkg::NVCR_DUMMY_LSB +: 4];

    // Status reports busy high, flag status reports ready high
    always_comb begin
        busy = 1'b0;
        if (state == xip_pkg::ST_STATUS_RSP) begin
            busy = rsp_data[xip_pkg::STATUS_BUSY_BIT];
        end else if (state == xip_pkg::ST_POLL_RSP) begin
            busy = !rsp_data[xip_pkg::FLAG_READY_BIT];
        end
    end

    // ****************************************
    // Operation flow
    // ****************************************
    always_comb begin
        next_state = state;
        case (state)
            xip_pkg::ST_IDLE: begin
                if (read_start) begin
                    next_state = xip_pkg::ST_CFG_CMD;
                end else if (write_start) begin
                    next_state = xip_pkg::ST_STATUS_CMD;
                end
            end
            // Command states hold until the stream takes the header
            xip_pkg::ST_STATUS_CMD: if (cmd_ready) next_state = xip_pkg::ST_STATUS_RSP;
            xip_pkg::ST_WREN_CMD:   if (cmd_ready) next_state = xip_pkg::ST_WREN_RSP;
            xip_pkg::ST_WR_CMD:     if (cmd_ready) next_state = xip_pkg::ST_WR_DATA;
            xip_pkg::ST_POLL_CMD:   if (cmd_ready) next_state = xip_pkg::ST_POLL_RSP;
            xip_pkg::ST_CFG_CMD:    if (cmd_ready) next_state = xip_pkg::ST_CFG_RSP;
            xip_pkg::ST_RD_CMD:     if (cmd_ready) next_state = xip_pkg::ST_RD_DATA;
            // Busy device sends us back for another status read
            xip_pkg::ST_STATUS_RSP: begin
                if (rsp_done) begin
                    next_state = busy ? xip_pkg::ST_STATUS_CMD : xip_pkg::ST_WREN_CMD;
                end
            end
            xip_pkg::ST_WREN_RSP: if (rsp_done) next_state = xip_pkg::ST_WR_CMD;
            // Write packet is answered once all of its words went out
            xip_pkg::ST_WR_DATA:  if (rsp_done) next_state = xip_pkg::ST_POLL_CMD;
            xip_pkg::ST_POLL_RSP: begin
                if (rsp_done) begin
                    next_state = busy ? xip_pkg::ST_POLL_CMD : xip_pkg::ST_COMPLETE;
                end
            end
            xip_pkg::ST_CFG_RSP:  if (rsp_done) next_state = xip_pkg::ST_RD_CMD;
            xip_pkg::ST_RD_DATA:  if (rsp_done) next_state = xip_pkg::ST_COMPLETE;
            default:              next_state = xip_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state           <= xip_pkg::ST_IDLE;
            dummy_count     <= xip_pkg::DEFAULT_DUMMY;
            mem_rddatavalid <= 1'b0;
        end else begin
            state           <= next_state;
            mem_rddatavalid <= (state == xip_pkg::ST_RD_DATA) && rsp_valid;
            // Erased or unset field falls back to the default count
            if (state == xip_pkg::ST_CFG_RSP && rsp_done) begin
                if (cfg_dummy == 4'h0 || cfg_dummy == 4'hF) begin
                    dummy_count <= xip_pkg::DEFAULT_DUMMY;
                end else begin
                    dummy_count <= {1'b0, cfg_dummy};
                end
            end
        end
    end

    // Read beats reach the host one cycle later
    always_ff @(posedge clk) begin
        if (state == xip_pkg::ST_RD_DATA && rsp_valid) begin
            mem_rddata <= rsp_data;
        end
    end

    assign idle       = (state == xip_pkg::ST_IDLE);
    assign fifo.ready = (state == xip_pkg::ST_WR_DATA) && cmd_ready;

endmodule

//--- design/write_fifo.sv
`timescale 1ns/1ps

module write_fifo #(
    parameter int FIFO_DEPTH = 64
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       push,
    input  logic [xip_pkg::WORD_W-1:0] word,
    input  logic                       eop,
    word_stream_if.source              out
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    // Each entry is {eop, word}
    logic [xip_pkg::WORD_W:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]         wr_ptr;
    logic [PTR_W-1:0]         rd_ptr;
    logic [CNT_W-1:0]         count;
    logic                     pop;

    assign pop = out.valid && out.ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= {eop, word};
        end
    end

    // ****************************************
    // Pointers and fill level
    // ****************************************
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Explicit wrap keeps non power of two depths legal
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Head entry is shown without read latency
    assign out.valid = (count != '0);
    assign out.data  = mem[rd_ptr][xip_pkg::WORD_W-1:0];
    assign out.eop   = mem[rd_ptr][xip_pkg::WORD_W];

endmodule

//--- design/host_port.sv
`timescale 1ns/1ps

module host_port #(
    parameter int ADDR_W = 32
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [ADDR_W-1:0]           mem_addr,
    input  logic                        mem_rd,
    input  logic                        mem_wr,
    input  logic [xip_pkg::WORD_W-1:0]  mem_wrdata,
    input  logic [xip_pkg::BURST_W-1:0] mem_burstcount,
    input  logic                        idle,
    output logic                        mem_waitrequest,
    output logic                        read_start,
    output logic                        write_start,
    output logic                        fifo_push,
    output logic [xip_pkg::WORD_W-1:0]  fifo_word,
    output logic                        fifo_eop,
    output logic [xip_pkg::BURST_W-1:0] burst_len,
    output logic [ADDR_W-1:0]           addr_bytes_xip
);

    logic                        hold_wait;
    logic                        wr_accept;
    logic                        first_beat;
    logic [xip_pkg::BURST_W-1:0] words_left;
    logic [xip_pkg::BURST_W-1:0] cur_count;
    logic [ADDR_W-1:0]           addr_reg;

    // Waitrequest stays high for the first cycle out of reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hold_wait <= 1'b1;
        end else begin
            hold_wait <= 1'b0;
        end
    end

    assign mem_waitrequest = hold_wait || !idle;

    // Read wins if both strobes are seen together
    assign read_start = mem_rd && !mem_waitrequest;
    assign wr_accept  = mem_wr && !mem_rd && !mem_waitrequest;

    // ****************************************
    // Burst framing
    // ****************************************
    // Zero words left means the next beat opens a new burst
    assign first_beat = (words_left == '0);
    assign cur_count  = first_beat ? mem_burstcount : words_left;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            words_left <= '0;
        end else if (wr_accept) begin
            words_left <= cur_count - 1'b1;
        end
    end

    // Address and length are taken from the opening beat only
    always_ff @(posedge clk) begin
        if (read_start || (wr_accept && first_beat)) begin
            addr_reg  <= mem_addr;
            burst_len <= mem_burstcount;
        end
    end

    // Each write beat goes straight into the FIFO
    assign fifo_push   = wr_accept;
    assign fifo_word   = mem_wrdata;
    assign fifo_eop    = (cur_count == xip_pkg::BURST_W'(1));
    assign write_start = wr_accept && fifo_eop;

    // Word address to byte address
    assign addr_bytes_xip = {addr_reg[ADDR_W-3:0], 2'b00};

endmodule

//--- design/word_stream_if.sv
`timescale 1ns/1ps

// Word stream from the write FIFO toward the command stream
interface word_stream_if;
    logic [xip_pkg::WORD_W-1:0] data;
    logic                       eop;
    logic                       valid;
    logic                       ready;

    // FIFO side
    modport source (output data, output eop, output valid, input ready);

    // Consumer side where the sequencer drives ready
    modport sink (input data, input eop, input valid, output ready);

endinterface

//--- design/xip_pkg.sv
package xip_pkg;

    // ****************************************
    // Datapath and burst sizes
    // ****************************************
    localparam int WORD_W  = 32;
    localparam int BURST_W = 7;

    // Flash opcodes
    localparam logic [7:0] OP_READ_STATUS      = 8'h05;
    localparam logic [7:0] OP_WRITE_ENABLE     = 8'h06;
    localparam logic [7:0] OP_WRITE            = 8'h02;
    localparam logic [7:0] OP_READ_FLAG_STATUS = 8'h70;
    localparam logic [7:0] OP_READ_NVCR        = 8'hB5;
    localparam logic [7:0] OP_FAST_READ        = 8'h0B;

    // Response decode
    localparam int         STATUS_BUSY_BIT = 0;
    localparam int         FLAG_READY_BIT  = 7;
    localparam int         NVCR_DUMMY_LSB  = 12;
    localparam logic [4:0] DEFAULT_DUMMY   = 5'd8;

    // Operation flow of the sequencer
    typedef enum logic [3:0] {
        ST_IDLE, ST_STATUS_CMD, ST_STATUS_RSP, ST_WREN_CMD, ST_WREN_RSP,
        ST_WR_CMD, ST_WR_DATA, ST_POLL_CMD, ST_POLL_RSP, ST_CFG_CMD,
        ST_CFG_RSP, ST_RD_CMD, ST_RD_DATA, ST_COMPLETE
    } seq_state_t;

    // Command header word, top bit first
    typedef struct packed {
        logic       reserved;
        logic [3:0] chip_select;
        logic [8:0] data_bytes;
        logic [4:0] dummy;
        logic       has_dummy;
        logic       has_data_out;
        logic       has_data_in;
        logic       four_byte_addr;
        logic       has_addr;
        logic [7:0] opcode;
    } cmd_header_t;

endpackage
